//--- Bender.yml
package:
  name: uart

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_data_pkg.sv
      - uart_ctrl_pkg.sv
      - uart_rx.sv
      - uart_tx.sv
      - uart_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart.sv

//--- sim.f
+incdir+.
uart_data_pkg.sv
uart_ctrl_pkg.sv
uart_rx.sv
uart_tx.sv
uart_top.sv
tb_uart.sv

//--- tb_uart.sv
`timescale 1ns/100ps
`include "uart_consts.svh"

module tb_uart;

   localparam int bit_cycles = `UART_CLK_PER_BIT;
   localparam int wait_limit = 12 * `UART_CLK_PER_BIT; // one frame plus some slack

   logic                      clk;
   logic                      reset_n;
   logic                      rxd;
   logic                      rxd_drv;
   logic                      loop_en;
   uart_data_pkg::uart_byte_t rdata;
   logic                      rdata_ready;
   logic                      ferr;
   uart_data_pkg::uart_byte_t tx_data;
   logic                      tx_start;
   logic                      txd;
   logic                      tx_busy;
   logic [31:0]               rand_state;
   uart_data_pkg::uart_byte_t got_byte;
   logic                      got_ferr;

   assign rxd = loop_en ? txd : rxd_drv; // loopback feeds the transmitter into the receiver

   uart_top i_dut (
      .clk         (clk),
      .reset_n     (reset_n),
      .rxd         (rxd),
      .rdata       (rdata),
      .rdata_ready (rdata_ready),
      .ferr        (ferr),
      .tx_data     (tx_data),
      .tx_start    (tx_start),
      .txd         (txd),
      .tx_busy     (tx_busy)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input uart_data_pkg::uart_byte_t exp,
                             input uart_data_pkg::uart_byte_t act);
      if (act !== exp) begin
         abort_run($sformatf("** Error %s: expected 8'h%h, actual 8'h%h", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic send_frame(input uart_data_pkg::uart_byte_t value, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, value, 1'b0}; // start bit goes out first, then lsb first
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         #2 rxd_drv = frame[i];
         repeat (bit_cycles - 1) @(posedge clk);
      end
      @(posedge clk);
      #2 rxd_drv = 1'b1;
      repeat (bit_cycles) @(posedge clk); // one idle bit between frames
   endtask

   task automatic wait_rx_ready(input string name);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (rdata_ready !== 1'b1) begin
         if (cycles == wait_limit) begin
            abort_run($sformatf("%s: the receiver never reported a byte", name));
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
      got_byte = rdata;
      got_ferr = ferr;
   endtask

   task automatic strobe_tx(input uart_data_pkg::uart_byte_t value);
      @(posedge clk);
      #2;
      tx_data  = value;
      tx_start = 1'b1;
      @(posedge clk);
      #2;
      tx_start = 1'b0;
   endtask

   task automatic watch_tx_frame(input string name, input uart_data_pkg::uart_byte_t exp);
      int                        cycles;
      logic                      level;
      uart_data_pkg::uart_byte_t seen;
      seen   = '0;
      cycles = 0;
      @(negedge clk);
      while (txd !== 1'b0) begin
         if (cycles == wait_limit) begin
            abort_run($sformatf("%s: txd never fell to a start bit", name));
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
      // every bit must hold its level for exactly one bit period
      for (int b = 0; b < 10; b++) begin
         level = (b == 0) ? 1'b0 : ((b == 9) ? 1'b1 : txd); // data levels are judged mid bit
         for (int c = 0; c < bit_cycles; c++) begin
            check_flag($sformatf("%s txd bit %0d cycle %0d", name, b, c), level, txd);
            check_flag($sformatf("%s tx_busy in frame", name), 1'b1, tx_busy);
            if (c == bit_cycles / 2 && b >= 1 && b <= 8) begin
               seen[b - 1] = txd; // mid-bit sample
            end
            @(negedge clk);
         end
      end
      check_byte(name, exp, seen);
      check_flag($sformatf("%s tx_busy after stop", name), 1'b0, tx_busy);
   endtask

   task automatic verify_quiet_line(input string name);
      for (int c = 0; c < 2 * bit_cycles; c++) begin
         check_flag($sformatf("%s txd after frame", name), 1'b1, txd);
         check_flag($sformatf("%s tx_busy after frame", name), 1'b0, tx_busy);
         @(negedge clk);
      end
   endtask

   task automatic drain_tx(input string name);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (tx_busy !== 1'b0) begin
         if (cycles == wait_limit) begin
            abort_run($sformatf("%s: tx_busy stayed high", name));
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
   endtask

   task automatic run_vector(input string name, input string kind,
                             input uart_data_pkg::uart_byte_t value,
                             input logic stop_bit, input logic exp_ferr);
      uart_data_pkg::uart_byte_t loop_byte;
      if (kind == "R") begin
         fork
            send_frame(value, stop_bit);
            wait_rx_ready(name);
         join
         check_byte(name, value, got_byte);
         check_flag($sformatf("%s ferr", name), exp_ferr, got_ferr);
      end else if (kind == "T") begin
         fork
            watch_tx_frame(name, value);
            begin
               strobe_tx(value);
               repeat (3 * bit_cycles) @(posedge clk);
               strobe_tx(~value); // lands mid frame and has to be dropped
            end
         join
         verify_quiet_line(name);
      end else if (kind == "L") begin
         rand_state = xorshift(rand_state);
         loop_byte  = rand_state[7:0];
         @(posedge clk);
         #2 loop_en = 1'b1;
         fork
            strobe_tx(loop_byte);
            wait_rx_ready(name);
         join
         check_byte(name, loop_byte, got_byte);
         check_flag($sformatf("%s ferr", name), exp_ferr, got_ferr);
         drain_tx(name);
         @(posedge clk);
         #2 loop_en = 1'b0;
      end else begin
         abort_run($sformatf("%s: unknown test kind %s", name, kind));
      end
   endtask

   initial begin
      int                        fd;
      int                        code;
      int                        tests_run;
      logic                      more;
      string                     name;
      string                     kind;
      uart_data_pkg::uart_byte_t value;
      logic                      stop_bit;
      logic                      exp_ferr;
      logic [8*256-1:0]          rest;
      clk        = 1'b0;
      reset_n    = 1'b0;
      rxd_drv    = 1'b1;
      loop_en    = 1'b0;
      tx_data    = '0;
      tx_start   = 1'b0;
      rand_state = 32'h878a;
      tests_run  = 0;
      repeat (4) @(posedge clk);
      #2 reset_n = 1'b1;
      @(negedge clk);
      check_flag("reset txd", 1'b1, txd);
      check_flag("reset tx_busy", 1'b0, tx_busy);
      check_flag("reset rdata_ready", 1'b0, rdata_ready);
      check_flag("reset ferr", 1'b0, ferr);
      check_byte("reset rdata", 8'h00, rdata);
      fd = $fopen("uart_tests.txt", "r");
      if (fd == 0) begin
         abort_run("could not open uart_tests.txt");
      end else begin
         more = 1'b1;
         while (more) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) begin
               more = 1'b0;
            end else if (name[0] == "#") begin
               code = $fgets(rest, fd); // skip the rest of a comment line
            end else begin
               code = $fscanf(fd, "%s %h %b %b", kind, value, stop_bit, exp_ferr);
               if (code != 4) begin
                  abort_run($sformatf("test line %s is incomplete", name));
               end else begin
                  run_vector(name, kind, value, stop_bit, exp_ferr);
                  tests_run++;
               end
            end
         end
         $fclose(fd);
         if (tests_run == 0) begin
            abort_run("uart_tests.txt held no test lines");
         end else begin
            $display("sim passed");
            $finish;
         end
      end
   end

endmodule

//--- uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

`define UART_CLK_PER_HALF_BIT 4 // short bit period keeps simulation fast
`define UART_CLK_PER_BIT (`UART_CLK_PER_HALF_BIT * 2)

// frame end in the stop bit, counted from its start
`define UART_CLK_PER_STOP ((`UART_CLK_PER_BIT * 9) / 10 - 1)

`define UART_CNT_W 8 // wide enough for the largest bit period

`endif

//--- uart_ctrl_pkg.sv
package uart_ctrl_pkg;

   // receiver walks the frame one bit period at a time
   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   // transmitter holds each level for one bit period
   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

endpackage

//--- uart_data_pkg.sv
`include "uart_consts.svh"

package uart_data_pkg;

   // one data byte of an 8N1 frame
   typedef logic [7:0] uart_byte_t;

   // position of a data bit inside the frame, lsb first
   typedef logic [2:0] uart_bit_idx_t;

   // clock cycles inside one bit period
   typedef logic [`UART_CNT_W-1:0] uart_cnt_t;

endpackage

//--- uart_rx.sv
`timescale 1ns/100ps
`include "uart_consts.svh"

module uart_rx (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      rxd,
   output uart_data_pkg::uart_byte_t rdata,
   output logic                      rdata_ready,
   output logic                      ferr
);

   localparam uart_data_pkg::uart_cnt_t half_last =
      uart_data_pkg::uart_cnt_t'(`UART_CLK_PER_HALF_BIT - 1);
   localparam uart_data_pkg::uart_cnt_t bit_last =
      uart_data_pkg::uart_cnt_t'(`UART_CLK_PER_BIT - 1);
   localparam uart_data_pkg::uart_cnt_t stop_last =
      uart_data_pkg::uart_cnt_t'(`UART_CLK_PER_STOP);

   uart_ctrl_pkg::rx_state_t     state;
   uart_data_pkg::uart_cnt_t     counter;
   uart_data_pkg::uart_bit_idx_t bit_idx;
   logic                         rxd_q;
   logic                         start_det;
   logic                         mid_bit;
   logic                         stop_pt;
   logic                         stop_seen;

   // a start bit is a falling edge seen while idle, so a low stop bit is not taken as one
   assign start_det = (state == uart_ctrl_pkg::rx_idle) && rxd_q && !rxd;
   assign mid_bit   = (counter == half_last);
   assign stop_pt   = (counter == stop_last);

   // bit counter is aligned to the bit edges by the start bit
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         counter <= '0;
      end else if (start_det || counter == bit_last) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state       <= uart_ctrl_pkg::rx_idle;
         bit_idx     <= '0;
         rdata       <= '0;
         rdata_ready <= 1'b0;
         ferr        <= 1'b0;
         rxd_q       <= 1'b1; // line idles high
         stop_seen   <= 1'b0;
      end else begin
         rxd_q       <= rxd;
         rdata_ready <= 1'b0;
         case (state)
            uart_ctrl_pkg::rx_idle: begin
               if (start_det) begin
                  state <= uart_ctrl_pkg::rx_start;
                  ferr  <= 1'b0;
               end
            end
            uart_ctrl_pkg::rx_start: begin
               if (mid_bit) begin
                  state   <= uart_ctrl_pkg::rx_data;
                  bit_idx <= '0;
               end
            end
            uart_ctrl_pkg::rx_data: begin
               if (mid_bit) begin
                  rdata[bit_idx] <= rxd;
                  bit_idx        <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= uart_ctrl_pkg::rx_stop;
                  end
               end
            end
            uart_ctrl_pkg::rx_stop: begin
               // the byte is reported mid stop bit, the frame ends near its close
               if (mid_bit && !stop_seen) begin
                  rdata_ready <= 1'b1;
                  ferr        <= !rxd;
                  stop_seen   <= 1'b1;
               end else if (stop_pt && stop_seen) begin
                  state     <= uart_ctrl_pkg::rx_idle;
                  stop_seen <= 1'b0;
               end
            end
            default: begin
               state <= uart_ctrl_pkg::rx_idle;
            end
         endcase
      end
   end

   a_ready_pulse: assert property (
      @(posedge clk) disable iff (!reset_n)
      rdata_ready |=> !rdata_ready
   );

   // the byte is reported one bit period after the last data sample
   a_ready_in_stop: assert property (
      @(posedge clk) disable iff (!reset_n)
      $rose(rdata_ready) |->
         state == uart_ctrl_pkg::rx_stop &&
         $past(state, `UART_CLK_PER_BIT) == uart_ctrl_pkg::rx_stop &&
         $past(state, `UART_CLK_PER_BIT + 1) == uart_ctrl_pkg::rx_data
   );

endmodule

//--- uart_tests.txt
# name kind byte stop_bit exp_ferr (byte in hex)
# kind R receives a frame, T transmits one, L loops txd to rxd with a random byte
rx_zero R 00 1 0
rx_ones R ff 1 0
rx_a5 R a5 1 0
rx_5a R 5a 1 0
rx_lsb R 01 1 0
rx_msb R 80 1 0
rx_3c R 3c 1 0
rx_bad_stop R c3 0 1
rx_after_bad R 7e 1 0
rx_bad_zero R 00 0 1
rx_recover R 96 1 0
tx_zero T 00 1 0
tx_ones T ff 1 0
tx_a5 T a5 1 0
tx_lsb T 01 1 0
tx_msb T 80 1 0
tx_e7 T e7 1 0
tx_18 T 18 1 0
loop_0 L 00 1 0
loop_1 L 00 1 0
loop_2 L 00 1 0
loop_3 L 00 1 0
loop_4 L 00 1 0
loop_5 L 00 1 0
loop_6 L 00 1 0
loop_7 L 00 1 0
rx_final R 69 1 0
tx_final T 4b 1 0

//--- uart_top.sv
`timescale 1ns/100ps

module uart_top (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      rxd,
   output uart_data_pkg::uart_byte_t rdata,
   output logic                      rdata_ready,
   output logic                      ferr,
   input  uart_data_pkg::uart_byte_t tx_data,
   input  logic                      tx_start,
   output logic                      txd,
   output logic                      tx_busy
);

   // receive and transmit run side by side and share only the clock and reset
   uart_rx i_rx (
      .clk         (clk),
      .reset_n     (reset_n),
      .rxd         (rxd),
      .rdata       (rdata),
      .rdata_ready (rdata_ready),
      .ferr        (ferr)
   );

   uart_tx i_tx (
      .clk      (clk),
      .reset_n  (reset_n),
      .tx_data  (tx_data),
      .tx_start (tx_start),
      .txd      (txd),
      .tx_busy  (tx_busy)
   );

endmodule

//--- uart_tx.sv
`timescale 1ns/100ps
`include "uart_consts.svh"

module uart_tx (
   input  logic                      clk,
   input  logic                      reset_n,
   input  uart_data_pkg::uart_byte_t tx_data,
   input  logic                      tx_start,
   output logic                      txd,
   output logic                      tx_busy
);

   localparam uart_data_pkg::uart_cnt_t bit_last =
      uart_data_pkg::uart_cnt_t'(`UART_CLK_PER_BIT - 1);

   uart_ctrl_pkg::tx_state_t     state;
   uart_data_pkg::uart_cnt_t     counter;
   uart_data_pkg::uart_bit_idx_t bit_idx;
   uart_data_pkg::uart_byte_t    shreg;
   logic                         accept;
   logic                         bit_end;

   assign accept  = (state == uart_ctrl_pkg::tx_idle) && tx_start; // strobes while busy drop here
   assign bit_end = (counter == bit_last);

   // data bits leave from the low end of the shift register
   always_ff @(posedge clk) begin
      if (accept) begin
         shreg <= tx_data;
      end else if (bit_end && state != uart_ctrl_pkg::tx_idle) begin
         shreg <= shreg >> 1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state   <= uart_ctrl_pkg::tx_idle;
         counter <= '0;
         bit_idx <= '0;
         txd     <= 1'b1;
         tx_busy <= 1'b0;
      end else begin
         if (state == uart_ctrl_pkg::tx_idle || bit_end) begin
            counter <= '0;
         end else begin
            counter <= counter + 1'b1;
         end
         case (state)
            uart_ctrl_pkg::tx_idle: begin
               if (accept) begin
                  state   <= uart_ctrl_pkg::tx_start;
                  txd     <= 1'b0;
                  tx_busy <= 1'b1;
               end
            end
            uart_ctrl_pkg::tx_start: begin
               if (bit_end) begin
                  state   <= uart_ctrl_pkg::tx_data;
                  txd     <= shreg[0];
                  bit_idx <= '0;
               end
            end
            uart_ctrl_pkg::tx_data: begin
               if (bit_end) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= uart_ctrl_pkg::tx_stop;
                     txd   <= 1'b1;
                  end else begin
                     txd <= shreg[0];
                  end
               end
            end
            uart_ctrl_pkg::tx_stop: begin
               if (bit_end) begin
                  state   <= uart_ctrl_pkg::tx_idle;
                  tx_busy <= 1'b0;
               end
            end
            default: begin
               state <= uart_ctrl_pkg::tx_idle;
            end
         endcase
      end
   end

   a_idle_high: assert property (
      @(posedge clk) disable iff (!reset_n)
      !tx_busy |-> txd
   );

   // busy only ends after a full stop bit
   a_busy_from_stop: assert property (
      @(posedge clk) disable iff (!reset_n)
      $fell(tx_busy) |->
         $past(state) == uart_ctrl_pkg::tx_stop &&
         $past(state, `UART_CLK_PER_BIT) == uart_ctrl_pkg::tx_stop &&
         $past(state, `UART_CLK_PER_BIT + 1) == uart_ctrl_pkg::tx_data
   );

endmodule
